//--- hdl/ptw_pkg.sv
// Shared Sv39 walker widths, PTE bit positions and state types, imported by the RTL and testbench
`default_nettype none

package ptw_pkg;

    // --------------------------------------------------------------------
    // address and page number widths
    // --------------------------------------------------------------------
    localparam int PLEN          = 56;
    localparam int VLEN          = 39;
    localparam int PPNW          = 44;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = 9;

    typedef logic [PLEN-1:0]               paddr_t;
    typedef logic [VLEN-1:0]               vaddr_t;
    typedef logic [PPNW-1:0]               ppn_t;
    typedef logic [VLEN-PAGE_OFFSET_W-1:0] vpn_t;
    typedef logic [63:0]                   pte_t;

    // --------------------------------------------------------------------
    // PTE field positions
    // --------------------------------------------------------------------
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    // upper reserved bits 63:54 and the rsw pair 9:8 must read as zero
    localparam pte_t PTE_RSV_MASK = 64'hFFC0_0000_0000_0300;

    // three Sv39 levels, 1G down to 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

endpackage

`default_nettype wire

//--- hdl/ptw_ifs.sv
// Interfaces between the walk controller and its PTE checker and pointer generator
`timescale 1ns/1ns
`default_nettype none

// --------------------------------------------------------------------
// controller to PTE checker, purely combinational
// --------------------------------------------------------------------
interface pte_chk_if import ptw_pkg::*; ();

    pte_t   pte;
    level_e level;
    logic   is_instr;
    logic   is_store;
    logic   mxr;
    logic   is_leaf;
    logic   fault;

    modport ctrl (output pte, level, is_instr, is_store, mxr, input is_leaf, fault);
    modport check (input pte, level, is_instr, is_store, mxr, output is_leaf, fault);

endinterface

// --------------------------------------------------------------------
// controller to pointer generator
// --------------------------------------------------------------------
interface pptr_if import ptw_pkg::*; ();

    // start loads the walked address, step loads the next level pointer
    logic   start;
    vaddr_t start_vaddr;
    logic   step;
    ppn_t   next_ppn;
    level_e level;
    paddr_t pptr;
    vaddr_t vaddr;

    modport ctrl (output start, start_vaddr, step, next_ppn, level);
    modport gen (input start, start_vaddr, step, next_ppn, level, output pptr, vaddr);

endinterface

`default_nettype wire

//--- hdl/pte_check.sv
// Combinational Sv39 PTE classifier, tells the walk controller pointer, leaf or fault
`timescale 1ns/1ns
`default_nettype none

module pte_check import ptw_pkg::*; (
    pte_chk_if.check chk
);

    pte_t pte;
    logic valid;
    logic leaf;
    logic rsv_set;
    logic w_no_r;
    logic perm_ok;
    logic misaligned;
    logic ptr_bad;

    assign pte = chk.pte;

    // --------------------------------------------------------------------
    // basic encoding
    // --------------------------------------------------------------------
    assign valid   = pte[PTE_V];
    assign leaf    = valid && (pte[PTE_R] || pte[PTE_X]);
    assign rsv_set = |(pte & PTE_RSV_MASK);
    // write-only pages are a reserved encoding
    assign w_no_r  = pte[PTE_W] && !pte[PTE_R];

    // --------------------------------------------------------------------
    // leaf checks
    // --------------------------------------------------------------------
    always_comb begin : leaf_perm
        if (chk.is_instr) begin
            perm_ok = pte[PTE_X] && pte[PTE_A];
        end else begin
            // MXR makes execute-only pages readable
            perm_ok = pte[PTE_A] && (pte[PTE_R] || (pte[PTE_X] && chk.mxr));
            if (chk.is_store && (!pte[PTE_W] || !pte[PTE_D])) begin
                perm_ok = 1'b0;
            end
        end
    end

    // superpage ppn must be aligned to its own size
    always_comb begin : superpage_align
        case (chk.level)
            LVL1:    misaligned = |pte[PTE_PPN_LSB +: 2*VPN_W];
            LVL2:    misaligned = |pte[PTE_PPN_LSB +: VPN_W];
            default: misaligned = 1'b0;
        endcase
    end

    // --------------------------------------------------------------------
    // pointer checks
    // --------------------------------------------------------------------
    // A, D and U are reserved on non-leaf entries, and 4K has no level below
    assign ptr_bad = pte[PTE_A] || pte[PTE_D] || pte[PTE_U] || (chk.level == LVL3);

    assign chk.is_leaf = leaf;
    assign chk.fault   = !valid || w_no_r || rsv_set ||
                         (leaf ? (!perm_ok || misaligned) : ptr_bad);

endmodule

`default_nettype wire

//--- hdl/pptr_gen.sv
// Holds the virtual address under walk and forms the physical PTE address of each level
`timescale 1ns/1ns
`default_nettype none

module pptr_gen import ptw_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire ppn_t satp_ppn_i,
    pptr_if.gen       gen
);

    vaddr_t                 vaddr_q;
    paddr_t                 pptr_q;
    logic [VPN_W-1:0]       vpn_field;
    logic [VPN_W-1:0]       root_vpn;

    // VPN[2] of the incoming address indexes the root table
    assign root_vpn = gen.start_vaddr[VLEN-1 -: VPN_W];

    // --------------------------------------------------------------------
    // VPN field of the level being entered
    // --------------------------------------------------------------------
    always_comb begin : vpn_select
        case (gen.level)
            LVL2:    vpn_field = vaddr_q[PAGE_OFFSET_W + VPN_W +: VPN_W];
            LVL3:    vpn_field = vaddr_q[PAGE_OFFSET_W +: VPN_W];
            default: vpn_field = vaddr_q[PAGE_OFFSET_W + 2*VPN_W +: VPN_W];
        endcase
    end

    // --------------------------------------------------------------------
    // address registers
    // --------------------------------------------------------------------
    // entries are 8 bytes, so the index is shifted by three
    always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_regs
        if (!rst_ni) begin
            vaddr_q <= '0;
            pptr_q  <= '0;
        end else begin
            if (gen.start) begin
                vaddr_q <= gen.start_vaddr;
                pptr_q  <= {satp_ppn_i, root_vpn, 3'b000};
            end else if (gen.step) begin
                pptr_q  <= {gen.next_ppn, vpn_field, 3'b000};
            end
        end
    end

    assign gen.pptr  = pptr_q;
    assign gen.vaddr = vaddr_q;

endmodule

`default_nettype wire

//--- hdl/walk_ctrl.sv
// Sv39 walk FSM: picks a TLB miss, sequences PTE reads, handles flush and emits result pulses
`timescale 1ns/1ns
`default_nettype none

module walk_ctrl import ptw_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  flush_i,
    input  wire logic                  enable_translation_i,
    input  wire logic                  en_ld_st_translation_i,
    input  wire logic                  lsu_is_store_i,
    input  wire logic                  mxr_i,
    input  wire logic [ASID_WIDTH-1:0] asid_i,
    input  wire logic                  itlb_access_i,
    input  wire logic                  itlb_hit_i,
    input  wire vaddr_t                itlb_vaddr_i,
    input  wire logic                  dtlb_access_i,
    input  wire logic                  dtlb_hit_i,
    input  wire vaddr_t                dtlb_vaddr_i,
    input  wire logic                  mem_gnt_i,
    input  wire logic                  mem_rvalid_i,
    input  wire pte_t                  mem_rdata_i,
    output logic                       mem_req_o,
    output logic                       itlb_update_o,
    output logic                       dtlb_update_o,
    output pte_t                       update_pte_o,
    output logic                       update_is_2m_o,
    output logic                       update_is_1g_o,
    output logic [ASID_WIDTH-1:0]      update_asid_o,
    output logic                       ptw_error_o,
    output logic                       ptw_active_o,
    output logic                       walking_instr_o,
    pte_chk_if.ctrl                    chk,
    pptr_if.ctrl                       ptr
);

    walk_state_e           state_q, state_d;
    level_e                level_q, level_d;
    level_e                next_level;
    logic                  is_instr_q, is_instr_d;
    logic                  global_q, global_d;
    logic [ASID_WIDTH-1:0] asid_q, asid_d;
    logic                  rvalid_q;
    pte_t                  rdata_q;
    logic                  itlb_miss;
    logic                  dtlb_miss;

    // an instruction miss yields to any data access in the same cycle
    assign itlb_miss  = enable_translation_i && itlb_access_i && !itlb_hit_i && !dtlb_access_i;
    assign dtlb_miss  = en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;
    assign next_level = (level_q == LVL1) ? LVL2 : LVL3;

    // helpers see the registered PTE
    assign chk.pte      = rdata_q;
    assign chk.level    = level_q;
    assign chk.is_instr = is_instr_q;
    assign chk.is_store = lsu_is_store_i;
    assign chk.mxr      = mxr_i;

    assign ptr.start_vaddr = itlb_miss ? itlb_vaddr_i : dtlb_vaddr_i;
    assign ptr.next_ppn    = rdata_q[PTE_PPN_LSB +: PPNW];
    assign ptr.level       = next_level;

    assign mem_req_o       = (state_q == WAIT_GRANT);
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;

    // --------------------------------------------------------------------
    // TLB update payload, valid only with an update pulse
    // --------------------------------------------------------------------
    assign update_pte_o   = rdata_q | (pte_t'(global_q) << PTE_G);
    assign update_is_2m_o = (level_q == LVL2);
    assign update_is_1g_o = (level_q == LVL1);
    assign update_asid_o  = asid_q;

    // --------------------------------------------------------------------
    // walk FSM
    // --------------------------------------------------------------------
    always_comb begin : walk_fsm
        state_d       = state_q;
        level_d       = level_q;
        is_instr_d    = is_instr_q;
        global_d      = global_q;
        asid_d        = asid_q;
        ptr.start     = 1'b0;
        ptr.step      = 1'b0;
        itlb_update_o = 1'b0;
        dtlb_update_o = 1'b0;
        ptw_error_o   = 1'b0;

        case (state_q)
            IDLE: begin
                level_d    = LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                if (itlb_miss || dtlb_miss) begin
                    is_instr_d = itlb_miss;
                    asid_d     = asid_i;
                    ptr.start  = !flush_i;
                    state_d    = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    // global on any level makes the whole mapping global
                    if (rdata_q[PTE_G]) begin
                        global_d = 1'b1;
                    end
                    if (chk.fault) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (chk.is_leaf) begin
                        state_d       = IDLE;
                        itlb_update_o = is_instr_q && !flush_i;
                        dtlb_update_o = !is_instr_q && !flush_i;
                    end else begin
                        state_d  = WAIT_GRANT;
                        level_d  = next_level;
                        ptr.step = !flush_i;
                    end
                end
            end
            PROPAGATE_ERROR: begin
                state_d     = IDLE;
                ptw_error_o = !flush_i;
            end
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // a granted read still returns data, drain it before going idle
        if (flush_i) begin
            if ((state_q == PTE_LOOKUP && !rvalid_q) || (state_q == WAIT_GRANT && mem_gnt_i)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            state_q    <= IDLE;
            level_q    <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            level_q    <= level_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        asid_q  <= asid_d;
        rdata_q <= mem_rdata_i;
    end

endmodule

`default_nettype wire

//--- hdl/sv39_ptw.sv
// Sv39 page-table walker top, connects controller, checker and pointer generator to plain ports
`timescale 1ns/1ns
`default_nettype none

module sv39_ptw import ptw_pkg::*; #(
    parameter int ASID_WIDTH = 16
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  flush_i,
    input  wire logic                  enable_translation_i,
    input  wire logic                  en_ld_st_translation_i,
    input  wire logic                  lsu_is_store_i,
    input  wire logic                  mxr_i,
    input  wire ppn_t                  satp_ppn_i,
    input  wire logic [ASID_WIDTH-1:0] asid_i,
    // TLB miss requests
    input  wire logic                  itlb_access_i,
    input  wire logic                  itlb_hit_i,
    input  wire vaddr_t                itlb_vaddr_i,
    input  wire logic                  dtlb_access_i,
    input  wire logic                  dtlb_hit_i,
    input  wire vaddr_t                dtlb_vaddr_i,
    // PTE read port
    output logic                       mem_req_o,
    output paddr_t                     mem_addr_o,
    input  wire logic                  mem_gnt_i,
    input  wire logic                  mem_rvalid_i,
    input  wire pte_t                  mem_rdata_i,
    // TLB update
    output logic                       itlb_update_o,
    output logic                       dtlb_update_o,
    output vpn_t                       update_vpn_o,
    output pte_t                       update_pte_o,
    output logic                       update_is_2m_o,
    output logic                       update_is_1g_o,
    output logic [ASID_WIDTH-1:0]      update_asid_o,
    // status
    output logic                       ptw_error_o,
    output logic                       ptw_active_o,
    output logic                       walking_instr_o
);

    pte_chk_if chk_bus ();
    pptr_if    ptr_bus ();

    assign mem_addr_o   = ptr_bus.pptr;
    assign update_vpn_o = ptr_bus.vaddr[VLEN-1:PAGE_OFFSET_W];

    walk_ctrl #(
        .ASID_WIDTH (ASID_WIDTH)
    ) walk_ctrl_inst (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .mxr_i                  (mxr_i),
        .asid_i                 (asid_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .mem_gnt_i              (mem_gnt_i),
        .mem_rvalid_i           (mem_rvalid_i),
        .mem_rdata_i            (mem_rdata_i),
        .mem_req_o              (mem_req_o),
        .itlb_update_o          (itlb_update_o),
        .dtlb_update_o          (dtlb_update_o),
        .update_pte_o           (update_pte_o),
        .update_is_2m_o         (update_is_2m_o),
        .update_is_1g_o         (update_is_1g_o),
        .update_asid_o          (update_asid_o),
        .ptw_error_o            (ptw_error_o),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .chk                    (chk_bus.ctrl),
        .ptr                    (ptr_bus.ctrl)
    );

    pte_check pte_check_inst (
        .chk (chk_bus.check)
    );

    pptr_gen pptr_gen_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .satp_ppn_i (satp_ppn_i),
        .gen        (ptr_bus.gen)
    );

endmodule

`default_nettype wire

//--- verification/ptw_tb.sv
// Self-checking simulation top that runs the Sv39 walker against a page-table model and reference walk
`timescale 1ns/1ns
`default_nettype none

module ptw_tb import ptw_pkg::*; ();

    localparam int   ASID_WIDTH = 16;
    localparam int   TIMEOUT    = 200;
    localparam ppn_t ROOT       = 44'h8_0000;

    typedef logic [ASID_WIDTH-1:0] asid_t;
    typedef struct packed {
        logic fault;
        logic is_1g;
        logic is_2m;
        pte_t pte;
    } walk_result_t;

    logic   clk = 1'b0;
    logic   rst_n, flush, is_store, mxr;
    asid_t  asid, update_asid;
    logic   itlb_access, dtlb_access;
    vaddr_t itlb_vaddr, dtlb_vaddr;
    logic   mem_req, mem_gnt, mem_rvalid;
    paddr_t mem_addr;
    pte_t   mem_rdata, update_pte;
    logic   itlb_update, dtlb_update, update_is_2m, update_is_1g;
    vpn_t   update_vpn;
    logic   ptw_error, ptw_active, walking_instr;

    pte_t         page_mem [paddr_t];
    integer       seed = 32'h9cd8_ef74;
    walk_result_t expected;
    vpn_t         exp_vpn;
    logic         exp_instr;
    asid_t        exp_asid;
    logic         expect_pending = 1'b0;
    logic         mem_busy = 1'b0;

    always #20 clk = ~clk;

    sv39_ptw #(
        .ASID_WIDTH (ASID_WIDTH)
    ) sv39_ptw_inst (
        .clk_i                  (clk),
        .rst_ni                 (rst_n),
        .flush_i                (flush),
        .enable_translation_i   (1'b1),
        .en_ld_st_translation_i (1'b1),
        .lsu_is_store_i         (is_store),
        .mxr_i                  (mxr),
        .satp_ppn_i             (ROOT),
        .asid_i                 (asid),
        .itlb_access_i          (itlb_access),
        .itlb_hit_i             (1'b0),
        .itlb_vaddr_i           (itlb_vaddr),
        .dtlb_access_i          (dtlb_access),
        .dtlb_hit_i             (1'b0),
        .dtlb_vaddr_i           (dtlb_vaddr),
        .mem_req_o              (mem_req),
        .mem_addr_o             (mem_addr),
        .mem_gnt_i              (mem_gnt),
        .mem_rvalid_i           (mem_rvalid),
        .mem_rdata_i            (mem_rdata),
        .itlb_update_o          (itlb_update),
        .dtlb_update_o          (dtlb_update),
        .update_vpn_o           (update_vpn),
        .update_pte_o           (update_pte),
        .update_is_2m_o         (update_is_2m),
        .update_is_1g_o         (update_is_1g),
        .update_asid_o          (update_asid),
        .ptw_error_o            (ptw_error),
        .ptw_active_o           (ptw_active),
        .walking_instr_o        (walking_instr)
    );

    // ----------------------------------------------------------------------
    // failure reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_pte(input pte_t got, input pte_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vpn(input vpn_t got, input vpn_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input paddr_t got, input paddr_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_asid(input asid_t got, input asid_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------------------
    // page table helpers and reference walk
    // ----------------------------------------------------------------------
    function automatic paddr_t entry_addr(input ppn_t table_ppn, input logic [8:0] idx);
        return {table_ppn, idx, 3'b000};
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    function automatic vaddr_t make_va(input logic [8:0] v2, input logic [8:0] v1,
                                       input logic [8:0] v0);
        return {v2, v1, v0, 12'h5a4};
    endfunction

    // unmapped addresses read as an invalid PTE
    function automatic pte_t read_pte(input paddr_t addr);
        if (page_mem.exists(addr)) begin
            return page_mem[addr];
        end
        return '0;
    endfunction

    function automatic walk_result_t ref_walk(input vaddr_t va, input logic instr,
                                              input logic store, input logic mx);
        walk_result_t res;
        ppn_t         table_ppn;
        ppn_t         align_mask;
        pte_t         pte;
        logic         glob;
        logic         perm;
        logic         done;
        res       = '0;
        table_ppn = ROOT;
        glob      = 1'b0;
        done      = 1'b0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            if (!done) begin
                pte        = read_pte({table_ppn, va[PAGE_OFFSET_W + 9*lvl +: 9], 3'b000});
                glob       = glob | pte[PTE_G];
                align_mask = (ppn_t'(1) << (9*lvl)) - 1;
                if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]) ||
                    pte[63:54] != 0 || pte[9:8] != 0) begin
                    res.fault = 1'b1;
                    done      = 1'b1;
                end else if (pte[PTE_R] || pte[PTE_X]) begin
                    if (instr) begin
                        perm = pte[PTE_X] && pte[PTE_A];
                    end else begin
                        perm = pte[PTE_A] && (pte[PTE_R] || (pte[PTE_X] && mx)) &&
                               (!store || (pte[PTE_W] && pte[PTE_D]));
                    end
                    res.fault = !perm || ((pte[53:10] & align_mask) != 0);
                    res.pte   = pte | (pte_t'(glob) << PTE_G);
                    res.is_1g = (lvl == 2);
                    res.is_2m = (lvl == 1);
                    done      = 1'b1;
                end else if (pte[PTE_A] || pte[PTE_D] || pte[PTE_U] || lvl == 0) begin
                    res.fault = 1'b1;
                    done      = 1'b1;
                end else begin
                    table_ppn = pte[53:10];
                end
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // memory model with random grant and response delays
    // ----------------------------------------------------------------------
    always begin : memory_model
        int     gnt_delay;
        int     rsp_delay;
        int     n;
        paddr_t addr;
        @(negedge clk);
        if (mem_req) begin
            mem_busy  = 1'b1;
            addr      = mem_addr;
            gnt_delay = $unsigned($random(seed)) % 4;
            n         = 0;
            // a flush may withdraw the request before the grant
            while (n < gnt_delay && mem_req) begin
                @(negedge clk);
                n++;
            end
            if (mem_req) begin
                check_addr(mem_addr, addr, "mem_addr_o held until grant");
                mem_gnt = 1'b1;
                @(negedge clk);
                mem_gnt   = 1'b0;
                rsp_delay = 1 + $unsigned($random(seed)) % 3;
                repeat (rsp_delay - 1) @(negedge clk);
                mem_rvalid = 1'b1;
                mem_rdata  = read_pte(addr);
                @(negedge clk);
                mem_rvalid = 1'b0;
                mem_rdata  = '0;
            end
            mem_busy = 1'b0;
        end
    end

    // every update or error pulse is compared with the reference result
    always @(posedge clk) begin : compare_results
        if (itlb_update || dtlb_update || ptw_error) begin
            if (!expect_pending) begin
                $display("error at %0t ns: result pulse with no walk pending", $time);
                abort_run();
            end else begin
                check_flag(ptw_error, expected.fault, "ptw_error_o");
                check_flag(walking_instr, exp_instr, "walking_instr_o");
                check_flag(itlb_update, !expected.fault && exp_instr, "itlb_update_o");
                check_flag(dtlb_update, !expected.fault && !exp_instr, "dtlb_update_o");
                if (!expected.fault) begin
                    check_pte(update_pte, expected.pte, "update_pte_o");
                    check_vpn(update_vpn, exp_vpn, "update_vpn_o");
                    check_flag(update_is_1g, expected.is_1g, "update_is_1g_o");
                    check_flag(update_is_2m, expected.is_2m, "update_is_2m_o");
                    check_asid(update_asid, exp_asid, "update_asid_o");
                end
                expect_pending = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    // compete raises an instruction miss alongside a data miss
    task automatic run_walk(input vaddr_t va, input logic instr, input logic store,
                            input logic mx, input logic compete);
        int cycles;
        @(negedge clk);
        is_store       = store;
        mxr            = mx;
        asid           = asid + 16'h0111;
        expected       = ref_walk(va, instr, store, mx);
        exp_vpn        = va[VLEN-1:PAGE_OFFSET_W];
        exp_instr      = instr;
        exp_asid       = asid;
        expect_pending = 1'b1;
        if (instr) begin
            itlb_vaddr  = va;
            itlb_access = 1'b1;
        end else begin
            dtlb_vaddr  = va;
            dtlb_access = 1'b1;
            itlb_vaddr  = make_va(9'd8, 9'd1, 9'd9);
            itlb_access = compete;
        end
        @(negedge clk);
        itlb_access = 1'b0;
        dtlb_access = 1'b0;
        cycles      = 0;
        while (expect_pending && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (expect_pending) begin
            $display("timed out waiting for the walk result");
            abort_run();
        end
    endtask

    task automatic flush_walk(input vaddr_t va, input int flush_delay);
        int cycles;
        @(negedge clk);
        is_store    = 1'b0;
        dtlb_vaddr  = va;
        dtlb_access = 1'b1;
        @(negedge clk);
        dtlb_access = 1'b0;
        repeat (flush_delay) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush  = 1'b0;
        cycles = 0;
        while ((ptw_active || mem_busy) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ptw_active || mem_busy) begin
            $display("timed out waiting for the walker to go idle after flush");
            abort_run();
        end
        // idle window in which any late pulse trips the compare process
        repeat (4) @(negedge clk);
    endtask

    initial begin : stimulus
        rst_n       = 1'b0;
        flush       = 1'b0;
        is_store    = 1'b0;
        mxr         = 1'b0;
        asid        = 16'h1a2b;
        itlb_access = 1'b0;
        dtlb_access = 1'b0;
        itlb_vaddr  = '0;
        dtlb_vaddr  = '0;
        mem_gnt     = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;

        // flags are D A G U X W R V from bit 7 down
        page_mem[entry_addr(ROOT, 9'd1)]        = make_pte(44'h8_0001, 8'h21);
        page_mem[entry_addr(44'h8_0001, 9'd2)]  = make_pte(44'h8_0002, 8'h01);
        page_mem[entry_addr(44'h8_0002, 9'd3)]  = make_pte(44'h1_2345, 8'hC7);
        page_mem[entry_addr(ROOT, 9'd4)]        = make_pte(44'h4_0000, 8'h43);
        page_mem[entry_addr(ROOT, 9'd5)]        = make_pte(44'h8_0010, 8'h01);
        page_mem[entry_addr(44'h8_0010, 9'd6)]  = make_pte(44'h0_0200, 8'h4B);
        page_mem[entry_addr(ROOT, 9'd7)]        = make_pte(44'h4_0001, 8'h43);
        page_mem[entry_addr(ROOT, 9'd8)]        = make_pte(44'h8_0020, 8'h01);
        page_mem[entry_addr(44'h8_0020, 9'd1)]  = make_pte(44'h8_0021, 8'h01);
        page_mem[entry_addr(44'h8_0021, 9'd9)]  = make_pte(44'h0_0777, 8'h49);
        page_mem[entry_addr(ROOT, 9'd9)]        = make_pte(44'hC_0000, 8'h43);
        page_mem[entry_addr(ROOT, 9'd10)]       = make_pte(44'h10_0000, 8'hC3);
        page_mem[entry_addr(ROOT, 9'd11)]       = make_pte(44'h14_0000, 8'h47);
        page_mem[entry_addr(ROOT, 9'd12)]       = make_pte(44'h18_0000, 8'h49);
        page_mem[entry_addr(ROOT, 9'd14)]       = make_pte(44'h8_0030, 8'h41);

        repeat (16) @(negedge clk);
        check_flag(mem_req, 1'b0, "mem_req_o after reset");
        check_flag(ptw_active, 1'b0, "ptw_active_o after reset");
        check_flag(ptw_error, 1'b0, "ptw_error_o after reset");
        check_flag(itlb_update | dtlb_update, 1'b0, "tlb update after reset");
        rst_n = 1'b1;

        run_walk(make_va(9'd1, 9'd2, 9'd3), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd1, 9'd2, 9'd3), 1'b0, 1'b1, 1'b0, 1'b0);
        run_walk(make_va(9'd4, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd5, 9'd6, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd7, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd8, 9'd1, 9'd9), 1'b1, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd9, 9'd0, 9'd0), 1'b1, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd1, 9'd2, 9'd3), 1'b0, 1'b0, 1'b0, 1'b1);
        run_walk(make_va(9'd10, 9'd0, 9'd0), 1'b0, 1'b1, 1'b0, 1'b0);
        run_walk(make_va(9'd11, 9'd0, 9'd0), 1'b0, 1'b1, 1'b0, 1'b0);
        run_walk(make_va(9'd11, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd12, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd12, 9'd0, 9'd0), 1'b0, 1'b0, 1'b1, 1'b0);
        run_walk(make_va(9'd13, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk(make_va(9'd14, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 1'b0);

        flush_walk(make_va(9'd1, 9'd2, 9'd3), 1);
        flush_walk(make_va(9'd1, 9'd2, 9'd3), 3);
        flush_walk(make_va(9'd1, 9'd2, 9'd3), 6);
        run_walk(make_va(9'd1, 9'd2, 9'd3), 1'b0, 1'b0, 1'b0, 1'b0);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/ptw_pkg.sv
hdl/ptw_ifs.sv
hdl/pte_check.sv
hdl/pptr_gen.sv
hdl/walk_ctrl.sv
hdl/sv39_ptw.sv
verification/ptw_tb.sv

//--- Bender.yml
package:
  name: sv39_ptw

sources:
  - hdl/ptw_pkg.sv
  - hdl/ptw_ifs.sv
  - hdl/pte_check.sv
  - hdl/pptr_gen.sv
  - hdl/walk_ctrl.sv
  - hdl/sv39_ptw.sv
  - target: simulation
    files:
      - verification/ptw_tb.sv
